//--- flist.f
+incdir+tests
verilog/fetch_pkg.sv
verilog/mem_pkg.sv
verilog/pc_gen.sv
verilog/icache.sv
verilog/predicted_npc.sv
verilog/instr_fifo.sv
verilog/ifu.sv
tests/tb_ifu.sv

//--- run.sh
#!/bin/sh
# build the ifu testbench with verilator and run it
# the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/10ps -Wno-fatal \
    -f flist.f --top-module tb_ifu \
    && ./obj_dir/Vtb_ifu > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TEST PASS" sim.log && echo "ifu simulation ok" || { echo "ifu simulation failed"; exit 1; }

//--- tests/tb_ifu_model.svh
`ifndef TB_IFU_MODEL_SVH
`define TB_IFU_MODEL_SVH

localparam logic [31:0] nop_word = 32'h0000_0013;   // addi x0 x0 0

logic [31:0] lcg_state = 32'h0ef68472;   // one generator for the whole bench

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

// jal x1 with a byte offset
function automatic logic [31:0] jal_word(input logic [31:0] off);
    return {off[20], off[10:1], off[11], off[19:12], 5'd1, 7'b1101111};
endfunction

// bne x1 x2 with a byte offset
function automatic logic [31:0] branch_word(input logic [31:0] off);
    return {off[12], off[10:5], 5'd2, 5'd1, 3'b001, off[4:1], off[11], 7'b1100011};
endfunction

// program image as a pure function of the word address
// every target stays inside 0 to 255
function automatic fetch_pkg::instr_t prog_word(input fetch_pkg::addr_t addr);
    logic [31:0] h;
    logic [31:0] fwd;
    logic [31:0] back;
    h    = (addr >> 2) * 32'h9e3779b1;   // spread the word address
    h    = h ^ (h >> 15);
    fwd  = 32'd4 * (32'd1 + 32'(h[22:20]));   // 4 to 32 bytes
    back = 32'd4 * (32'd8 + 32'(h[4:0]));     // 32 to 156 bytes
    if (addr >= 32'd224) begin
        return branch_word(-back);   // top of region always falls back
    end
    case (h[18:16])
        3'd4, 3'd5: return jal_word(fwd);
        3'd6:       return branch_word(32'd4 * (32'd1 + 32'(h[21:20])));   // not taken
        3'd7:       return (addr >= 32'd32) ? branch_word(-fwd) : nop_word;
        default:    return nop_word;
    endcase
endfunction

// expected entry for a pc, static rule
// jal taken, backward branch taken, all else falls through
function automatic fetch_pkg::ififo_entry_t ref_next(input fetch_pkg::addr_t pc);
    fetch_pkg::ififo_entry_t e;
    logic [31:0]             w;
    logic [31:0]             j_off;
    logic [31:0]             b_off;
    w     = prog_word(pc);
    j_off = 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));   // rv32 J layout
    b_off = 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));     // rv32 B layout
    e.instr       = w;
    e.pc          = pc;
    e.is_cond_br  = (w[6:0] == 7'h63);
    e.br_dir_pred = e.is_cond_br && b_off[31];   // negative offset
    if (w[6:0] == 7'h6f) begin
        e.br_target_pred = pc + j_off;
    end else if (e.br_dir_pred) begin
        e.br_target_pred = pc + b_off;
    end else begin
        e.br_target_pred = pc + 32'd4;
    end
    return e;
endfunction

task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        abort_run($sformatf("Fail %s got %h expected %h", name, got, exp));
    end
endtask

`endif

//--- tests/tb_ifu.sv
`timescale 1ns/10ps

module tb_ifu;

    localparam int num_entries      = 300;   // entries compared before the end
    localparam int dispatch_timeout = 200;   // cycles per wait

    logic                    clk;
    logic                    rst_n;
    fetch_pkg::addr_t        recovery_pc;
    logic                    recovery_pc_valid;
    logic                    backend_stall;
    logic                    mem_req_valid;
    mem_pkg::mem_req_t       mem_req;
    logic                    mem_resp_valid;
    mem_pkg::mem_resp_t      mem_resp;
    logic                    ififo_dispatch_ready;
    logic                    ififo_dispatch_valid;
    fetch_pkg::ififo_entry_t ififo_dispatch_data;

    fetch_pkg::addr_t        exp_pc;      // where the reference walk stands
    fetch_pkg::ififo_entry_t exp_entry;
    int                      entries_checked;

    logic                    req_open;    // refill seen and not answered yet
    logic                    resp_go;     // answer goes out at the next drive slot
    int                      resp_wait;
    mem_pkg::block_t         resp_data;

    logic [31:0]             rnd;
    int                      stall_left;
    int                      next_redirect_at;

    `include "tb_ifu_model.svh"

    ifu i_dut (
        .clk                  (clk),
        .rst_n                (rst_n),
        .recovery_pc          (recovery_pc),
        .recovery_pc_valid    (recovery_pc_valid),
        .backend_stall        (backend_stall),
        .mem_req_valid        (mem_req_valid),
        .mem_req              (mem_req),
        .mem_resp_valid       (mem_resp_valid),
        .mem_resp             (mem_resp),
        .ififo_dispatch_ready (ififo_dispatch_ready),
        .ififo_dispatch_valid (ififo_dispatch_valid),
        .ififo_dispatch_data  (ififo_dispatch_data)
    );

    always #5 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic wait_dispatch();
        int start_count;
        int cycles;
        start_count = entries_checked;
        cycles      = 0;
        while (entries_checked == start_count) begin
            @(posedge clk);
            cycles++;
            if (cycles > dispatch_timeout) begin
                abort_run("no entry reached dispatch within 200 cycles");
            end
        end
    endtask

    initial begin
        clk                  = 1'b0;
        rst_n                = 1'b0;
        recovery_pc          = '0;
        recovery_pc_valid    = 1'b0;
        backend_stall        = 1'b0;
        mem_resp_valid       = 1'b0;
        mem_resp             = '0;
        ififo_dispatch_ready = 1'b0;
        exp_pc               = '0;   // boot address
        entries_checked      = 0;
        req_open             = 1'b0;
        resp_go              = 1'b0;
        resp_wait            = 0;
        stall_left           = 0;
        next_redirect_at     = 50;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        while (entries_checked < num_entries) begin
            wait_dispatch();
        end
        $display("TEST PASS");
        $finish;
    end

    // inputs change 1 ns after the edge
    always @(posedge clk) begin
        if (rst_n) begin
            #1;
            rnd = lcg_next();
            ififo_dispatch_ready = rnd[16];   // ready about half the time
            if (stall_left > 0) begin
                backend_stall = 1'b1;
                stall_left--;
            end else begin
                backend_stall = 1'b0;
                if (rnd[23:20] == 4'd0) begin
                    stall_left = 1 + int'(rnd[26:24]);   // burst of 1 to 8
                end
            end
            recovery_pc_valid = 1'b0;   // pulse lasts one cycle
            if (entries_checked >= next_redirect_at) begin
                rnd = lcg_next();
                recovery_pc       = {24'd0, rnd[23:18], 2'b00};
                recovery_pc_valid = 1'b1;
                next_redirect_at  = entries_checked + 40 + int'((rnd >> 24) % 21);
            end
            mem_resp_valid = resp_go;
            if (resp_go) begin
                mem_resp.data = resp_data;
            end
        end
    end

    // outputs sampled mid cycle where they are settled
    always @(negedge clk) begin
        if (rst_n) begin
            if (mem_req_valid) begin
                if (req_open) begin
                    abort_run("refill request issued while the previous one was unanswered");
                end
                // block aligned and inside the program region
                check("mem_req.addr", mem_req.addr, mem_req.addr & 32'h0000_00f8);
                req_open  = 1'b1;
                resp_wait = 1 + int'((lcg_next() >> 16) % 6);   // 1 to 6 cycles
                resp_data = {prog_word(mem_req.addr + 32'd4), prog_word(mem_req.addr)};
            end else if (mem_resp_valid) begin
                req_open = 1'b0;   // consumed at the coming edge
                resp_go  = 1'b0;
            end else if (req_open && !resp_go) begin
                resp_wait--;
                resp_go = (resp_wait == 0);
            end
            if (ififo_dispatch_valid && ififo_dispatch_ready) begin
                exp_entry = ref_next(exp_pc);
                check("ififo_dispatch_data.pc", ififo_dispatch_data.pc, exp_entry.pc);
                check("ififo_dispatch_data.instr", ififo_dispatch_data.instr, exp_entry.instr);
                check("ififo_dispatch_data.is_cond_br", 32'(ififo_dispatch_data.is_cond_br),
                      32'(exp_entry.is_cond_br));
                check("ififo_dispatch_data.br_dir_pred", 32'(ififo_dispatch_data.br_dir_pred),
                      32'(exp_entry.br_dir_pred));
                check("ififo_dispatch_data.br_target_pred", ififo_dispatch_data.br_target_pred,
                      exp_entry.br_target_pred);
                exp_pc = exp_entry.br_target_pred;
                entries_checked++;
            end
            // flush at the coming edge so the walk restarts here
            if (recovery_pc_valid) begin
                exp_pc = recovery_pc;
            end
        end
    end

endmodule

//--- verilog/fetch_pkg.sv
package fetch_pkg;

    // core widths
    localparam int addr_width  = 32;
    localparam int instr_width = 32;

    // icache geometry, direct mapped, two instructions per block
    localparam int icache_num_sets    = 16;
    localparam int icache_index_bits  = 4;   // log2 of num_sets
    localparam int icache_offset_bits = 3;   // 8 bytes per block
    localparam int icache_tag_bits    = addr_width - icache_index_bits - icache_offset_bits;

    // instruction fifo toward dispatch
    localparam int ififo_depth    = 8;
    localparam int ififo_ptr_bits = $clog2(ififo_depth);

    // rv32 opcodes seen by the static predictor
    localparam logic [6:0] opcode_jal    = 7'b1101111;
    localparam logic [6:0] opcode_branch = 7'b1100011;

    localparam int pc_step = 4;   // sequential fetch stride

    typedef logic [addr_width-1:0]  addr_t;
    typedef logic [instr_width-1:0] instr_t;

    // one fetched instruction plus its prediction, 98 bits
    typedef struct packed {
        instr_t instr;
        addr_t  pc;
        logic   is_cond_br;      // branch opcode only
        logic   br_dir_pred;     // predicted taken
        addr_t  br_target_pred;  // predicted next pc
    } ififo_entry_t;

endpackage

//--- verilog/icache.sv
`timescale 1ns/10ps

module icache (
    input  logic                clk,
    input  logic                rst_n,
    input  fetch_pkg::addr_t    pc,
    output logic                hit,
    output fetch_pkg::instr_t   instr,
    // refill port
    output logic                mem_req_valid,   // one cycle pulse
    output mem_pkg::mem_req_t   mem_req,
    input  logic                mem_resp_valid,
    input  mem_pkg::mem_resp_t  mem_resp
);

    // arrays are plain flops, read combinationally
    logic [fetch_pkg::icache_tag_bits-1:0] tag_q  [fetch_pkg::icache_num_sets];
    logic [mem_pkg::block_width-1:0]       data_q [fetch_pkg::icache_num_sets];
    logic [fetch_pkg::icache_num_sets-1:0] valid_q;

    // outstanding refill
    logic                                    pending_q;
    logic [fetch_pkg::icache_index_bits-1:0] pend_idx_q;
    logic [fetch_pkg::icache_tag_bits-1:0]   pend_tag_q;

    logic [fetch_pkg::icache_index_bits-1:0] pc_idx;
    logic [fetch_pkg::icache_tag_bits-1:0]   pc_tag;
    logic [mem_pkg::block_width-1:0]         block;
    logic                                    miss_issue;
    logic                                    fill;

    assign pc_idx = pc[fetch_pkg::icache_offset_bits +: fetch_pkg::icache_index_bits];
    assign pc_tag = pc[fetch_pkg::addr_width-1 -: fetch_pkg::icache_tag_bits];

    // lookup
    assign hit   = valid_q[pc_idx] && (tag_q[pc_idx] == pc_tag);
    assign block = data_q[pc_idx];
    // pc bit 2 picks the upper or lower word
    assign instr = pc[2] ? block[mem_pkg::block_width-1 -: fetch_pkg::instr_width]
                         : block[fetch_pkg::instr_width-1:0];

    assign miss_issue = !hit && !pending_q;         // only one refill in flight
    assign fill       = mem_resp_valid && pending_q;

    // request address rebuilt from the saved index and tag
    assign mem_req.addr = {pend_tag_q, pend_idx_q, {fetch_pkg::icache_offset_bits{1'b0}}};

    // control state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q       <= '0;
            pending_q     <= 1'b0;
            mem_req_valid <= 1'b0;
        end else begin
            mem_req_valid <= 1'b0;           // default, pulse lasts one cycle
            if (fill) begin
                pending_q           <= 1'b0;
                valid_q[pend_idx_q] <= 1'b1;
            end else if (miss_issue) begin
                pending_q     <= 1'b1;
                mem_req_valid <= 1'b1;
            end
        end
    end

    // payload, no reset
    always_ff @(posedge clk) begin
        if (miss_issue) begin
            pend_idx_q <= pc_idx;            // remember which set to fill
            pend_tag_q <= pc_tag;
        end
        if (fill) begin
            data_q[pend_idx_q] <= mem_resp.data;
            tag_q[pend_idx_q]  <= pend_tag_q;
        end
    end

endmodule

//--- verilog/ifu.sv
`timescale 1ns/10ps

module ifu (
    input  logic                    clk,
    input  logic                    rst_n,
    // backend
    input  fetch_pkg::addr_t        recovery_pc,
    input  logic                    recovery_pc_valid,   // also flushes fifo
    input  logic                    backend_stall,
    // main memory, read only
    output logic                    mem_req_valid,
    output mem_pkg::mem_req_t       mem_req,
    input  logic                    mem_resp_valid,
    input  mem_pkg::mem_resp_t      mem_resp,
    // dispatch
    input  logic                    ififo_dispatch_ready,
    output logic                    ififo_dispatch_valid,
    output fetch_pkg::ififo_entry_t ififo_dispatch_data
);

    fetch_pkg::addr_t        pc;
    fetch_pkg::addr_t        next_pc;
    fetch_pkg::instr_t       instr;
    logic                    hit;
    logic                    is_cond_br;
    logic                    br_dir_pred;
    logic                    fetch_valid;
    logic                    enq_ready;
    fetch_pkg::ififo_entry_t enq_entry;

    pc_gen i_pc_gen (
        .clk               (clk),
        .rst_n             (rst_n),
        .recovery_pc       (recovery_pc),
        .recovery_pc_valid (recovery_pc_valid),
        .backend_stall     (backend_stall),
        .hit               (hit),
        .enq_ready         (enq_ready),
        .next_pc           (next_pc),
        .pc                (pc),
        .fetch_valid       (fetch_valid)
    );

    icache i_icache (
        .clk            (clk),
        .rst_n          (rst_n),
        .pc             (pc),
        .hit            (hit),
        .instr          (instr),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp       (mem_resp)
    );

    predicted_npc i_predicted_npc (
        .pc          (pc),
        .instr       (instr),
        .next_pc     (next_pc),
        .is_cond_br  (is_cond_br),
        .br_dir_pred (br_dir_pred)
    );

    // fifo entry built from wires only
    assign enq_entry.instr          = instr;
    assign enq_entry.pc             = pc;
    assign enq_entry.is_cond_br     = is_cond_br;
    assign enq_entry.br_dir_pred    = br_dir_pred;
    assign enq_entry.br_target_pred = next_pc;   // what pc moves to next

    instr_fifo #(
        .entry_t (fetch_pkg::ififo_entry_t)
    ) i_instr_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (recovery_pc_valid),   // wrong path entries dropped
        .enq_valid (fetch_valid),
        .enq_ready (enq_ready),
        .enq_data  (enq_entry),
        .deq_valid (ififo_dispatch_valid),
        .deq_ready (ififo_dispatch_ready),
        .deq_data  (ififo_dispatch_data)
    );

endmodule

//--- verilog/instr_fifo.sv
`timescale 1ns/10ps

module instr_fifo #(
    parameter type entry_t = fetch_pkg::ififo_entry_t
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   flush,       // drops everything at the edge
    // enqueue side
    input  logic   enq_valid,
    output logic   enq_ready,
    input  entry_t enq_data,
    // dequeue side
    output logic   deq_valid,
    input  logic   deq_ready,
    output entry_t deq_data
);

    entry_t                              mem_q [fetch_pkg::ififo_depth];
    logic [fetch_pkg::ififo_ptr_bits-1:0] wr_ptr_q;
    logic [fetch_pkg::ififo_ptr_bits-1:0] rd_ptr_q;
    logic [fetch_pkg::ififo_ptr_bits:0]   count_q;   // one extra bit for full
    logic                                 do_enq;
    logic                                 do_deq;

    // ready only looks at fill level, so push and pop work together
    assign enq_ready = (count_q != fetch_pkg::ififo_depth);
    assign deq_valid = (count_q != '0);
    assign deq_data  = mem_q[rd_ptr_q];   // head straight from storage flops

    assign do_enq = enq_valid && enq_ready;
    assign do_deq = deq_valid && deq_ready;

    // pointers and count
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_enq) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;   // wraps, depth is a power of two
            end
            if (do_deq) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({do_enq, do_deq})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;   // both or neither
            endcase
        end
    end

    // storage, no reset
    always_ff @(posedge clk) begin
        if (do_enq && !flush) begin
            mem_q[wr_ptr_q] <= enq_data;
        end
    end

endmodule

//--- verilog/mem_pkg.sv
package mem_pkg;

    // one refill moves a whole icache block
    localparam int block_width = 64;

    typedef logic [block_width-1:0] block_t;

    // refill request toward main memory
    typedef struct packed {
        fetch_pkg::addr_t addr;   // block aligned
    } mem_req_t;

    // refill response from main memory
    // lower word sits at the lower address
    typedef struct packed {
        block_t data;
    } mem_resp_t;

endpackage

//--- verilog/pc_gen.sv
`timescale 1ns/10ps

module pc_gen (
    input  logic             clk,
    input  logic             rst_n,
    // backend side
    input  fetch_pkg::addr_t recovery_pc,
    input  logic             recovery_pc_valid,  // one cycle, wins over all
    input  logic             backend_stall,
    // fetch datapath
    input  logic             hit,                // icache hit at current pc
    input  logic             enq_ready,          // fifo has room
    input  fetch_pkg::addr_t next_pc,            // from predictor
    output fetch_pkg::addr_t pc,
    output logic             fetch_valid         // current instr goes into fifo
);

    logic             stall;
    fetch_pkg::addr_t pc_d;

    // miss, full fifo or backend hold all freeze fetch
    assign stall = !hit || !enq_ready || backend_stall;

    // hand over only when nothing holds and no redirect pending
    assign fetch_valid = !stall && !recovery_pc_valid;

    // three way pc select
    always_comb begin
        if (recovery_pc_valid) begin
            pc_d = recovery_pc;      // redirect
        end else if (stall) begin
            pc_d = pc;               // hold
        end else begin
            pc_d = next_pc;          // predicted path
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;                // boot from address 0
        end else begin
            pc <= pc_d;
        end
    end

endmodule

//--- verilog/predicted_npc.sv
`timescale 1ns/10ps

module predicted_npc (
    input  fetch_pkg::addr_t  pc,
    input  fetch_pkg::instr_t instr,
    output fetch_pkg::addr_t  next_pc,
    output logic              is_cond_br,
    output logic              br_dir_pred
);

    logic             is_jal;
    fetch_pkg::addr_t imm_j;
    fetch_pkg::addr_t imm_b;
    fetch_pkg::addr_t pc_seq;

    assign is_jal     = (instr[6:0] == fetch_pkg::opcode_jal);
    assign is_cond_br = (instr[6:0] == fetch_pkg::opcode_branch);

    // J immediate, bit 0 always zero
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                    instr[30:21], 1'b0};
    // B immediate
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                    instr[11:8], 1'b0};

    // backward branch means probably a loop, take it
    assign br_dir_pred = is_cond_br && imm_b[fetch_pkg::addr_width-1];

    assign pc_seq = pc + fetch_pkg::addr_t'(fetch_pkg::pc_step);

    always_comb begin
        if (is_jal) begin
            next_pc = pc + imm_j;            // jal always taken
        end else if (br_dir_pred) begin
            next_pc = pc + imm_b;
        end else begin
            next_pc = pc_seq;                // fall through, forward branch too
        end
    end

endmodule
